// File: common/mem_geom_pkg.sv
`default_nettype none

// geometry of the scratchpad and its lanes
package mem_geom_pkg;

   localparam int ADDR_W = 8;                    // word address, 256 words
   localparam int DATA_W = 32;                   // host word
   localparam int BYTE_W = 8;                    // parity granule

   // two lanes side by side, each with its own RAM
   localparam int LANES  = 2;
   localparam int LANE_W = DATA_W / LANES;       // 16 data bits per lane

   localparam int LANE_BYTES = LANE_W / BYTE_W;  // bytes per lane

   // stored word: data in the low bits, one parity bit per byte above it
   localparam int LANE_STORE_W = LANE_W + LANE_BYTES;

endpackage : mem_geom_pkg

`default_nettype wire

// File: common/host_if_pkg.sv
`default_nettype none

// host side of the scratchpad: byte enables, data word, handshake FSM
package host_if_pkg;

   import mem_geom_pkg::*;

   localparam int BE_W = DATA_W / BYTE_W;  // one enable per host byte

   // host port FSM encoding
   localparam int         HS_W      = 2;
   localparam logic [1:0] ST_IDLE   = 2'd0;  // waiting for req
   localparam logic [1:0] ST_ACCESS = 2'd1;  // strobe to the lanes
   localparam logic [1:0] ST_WAIT   = 2'd2;  // waiting for merge done
   localparam logic [1:0] ST_ACK    = 2'd3;  // ack held until req drops

   // one host word, seen whole or as lane halves
   // lane 0 sits in the low bits
   typedef union packed {
      logic [DATA_W-1:0]             word;  // host view
      logic [LANES-1:0][LANE_W-1:0]  lane;  // per-lane view
   } data_word_u;

endpackage : host_if_pkg

`default_nettype wire

// File: design/la_spram.sv
`default_nettype none

// behavioral single-port RAM, bit write mask, registered read
module la_spram #(
   parameter int DW = 32,  // word width
   parameter int AW = 10   // address width
) (
   input  wire logic          clk,
   input  wire logic          ce,     // access enable
   input  wire logic          we,     // write when ce also high
   input  wire logic [DW-1:0] wmask,  // per-bit write enable
   input  wire logic [AW-1:0] addr,
   input  wire logic [DW-1:0] din,
   output logic      [DW-1:0] dout    // old contents on a write cycle
);

   logic [DW-1:0] mem [2**AW];  // storage, no reset

   // masked write, bit by bit
   always_ff @(posedge clk) begin
      for (int i = 0; i < DW; i++) begin
         if (ce && we && wmask[i]) begin
            mem[addr][i] <= din[i];
         end
      end
   end

   // read on every enabled cycle, sees pre-write data
   always_ff @(posedge clk) begin
      if (ce) begin
         dout <= mem[addr];
      end
   end

endmodule : la_spram

`default_nettype wire

// File: parity_lane/parity_lane.sv
`default_nettype none

// one 16-bit lane of the scratchpad with byte parity
module parity_lane import mem_geom_pkg::*; (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  strobe,  // one-cycle access pulse
   input  wire logic                  we,
   input  wire logic [ADDR_W-1:0]     addr,
   input  wire logic [LANE_BYTES-1:0] be,      // this lane's byte enables
   input  wire logic [LANE_W-1:0]     wdata,
   input  wire logic                  inject,  // flip stored parity
   output logic      [LANE_W-1:0]     rdata,
   output logic                       err,     // parity mismatch on read
   output logic                       rvalid   // one cycle after strobe
);

   logic [LANE_STORE_W-1:0] wmask;     // bit mask incl. parity bits
   logic [LANE_STORE_W-1:0] din;
   logic [LANE_STORE_W-1:0] dout;      // RAM read word
   logic [LANE_BYTES-1:0]   wpar;      // parity to store
   logic [LANE_BYTES-1:0]   rpar;      // parity recomputed on read
   logic [LANE_BYTES-1:0]   spar;      // parity as stored

   // expand byte enables, build parity for write and read
   always_comb begin
      for (int b = 0; b < LANE_BYTES; b++) begin
         wmask[b*BYTE_W +: BYTE_W] = {BYTE_W{be[b]}};  // data bits of byte b
         wmask[LANE_W + b]         = be[b];            // its parity bit
         wpar[b] = (^wdata[b*BYTE_W +: BYTE_W]) ^ inject;  // even, or forced bad
         rpar[b] = ^dout[b*BYTE_W +: BYTE_W];
      end
   end

   assign din  = {wpar, wdata};             // parity above data
   assign spar = dout[LANE_STORE_W-1:LANE_W];

   la_spram #(
      .DW (LANE_STORE_W),
      .AW (ADDR_W)
   ) i_la_spram (
      .clk   (clk),
      .ce    (strobe),  // RAM reads at the strobe edge
      .we    (we),
      .wmask (wmask),
      .addr  (addr),
      .din   (din),
      .dout  (dout)
   );

   // read data is valid the cycle after the strobe
   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid <= 1'b0;
      end else begin
         rvalid <= strobe;
      end
   end

   assign rdata = dout[LANE_W-1:0];
   assign err   = rvalid & |(rpar ^ spar);  // any byte mismatch, only when valid

endmodule : parity_lane

`default_nettype wire

// File: design/lane_merge.sv
`default_nettype none

// joins the lane halves into one word and flags completion
module lane_merge import mem_geom_pkg::*, host_if_pkg::*; (
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic                          lane_valid,  // lane 0 rvalid
   input  wire logic [LANES-1:0][LANE_W-1:0]  lane_data,
   input  wire logic [LANES-1:0]              lane_err,
   output data_word_u                         rdata,       // held until next access
   output logic                               err,
   output logic                               done         // one-cycle pulse
);

   // lanes run in lockstep, so lane 0 valid covers both
   always_ff @(posedge clk) begin
      if (reset) begin
         rdata <= '0;
         err   <= 1'b0;
         done  <= 1'b0;
      end else begin
         done <= lane_valid;
         if (lane_valid) begin
            rdata.lane <= lane_data;  // lane 0 lands in the low half
            err        <= |lane_err;  // either lane bad marks the word
         end
      end
   end

endmodule : lane_merge

`default_nettype wire

// File: design/host_port.sv
`default_nettype none

// four-phase req/ack front end, one access per request
module host_port import mem_geom_pkg::*, host_if_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              req,
   input  wire logic              we,
   input  wire logic [ADDR_W-1:0] addr,
   input  wire logic [BE_W-1:0]   be,
   input  wire data_word_u        wdata,
   input  wire logic              inject,
   input  wire logic              done,        // word complete from merge
   output logic                   ack,
   output logic                   strobe,      // one pulse per request
   output logic                   acc_we,
   output logic      [ADDR_W-1:0] acc_addr,
   output logic      [BE_W-1:0]   acc_be,
   output data_word_u             acc_wdata,
   output logic                   acc_inject
);

   logic [HS_W-1:0] state;

   // handshake FSM
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE:   if (req) state <= ST_ACCESS;   // new request seen
            ST_ACCESS: state <= ST_WAIT;              // strobe lasts one cycle
            ST_WAIT:   if (done) state <= ST_ACK;
            ST_ACK:    if (!req) state <= ST_IDLE;    // host released req
            default:   state <= ST_IDLE;
         endcase
      end
   end

   // request fields held for the lanes through the access
   always_ff @(posedge clk) begin
      if (state == ST_IDLE && req) begin
         acc_we         <= we;
         acc_addr       <= addr;
         acc_be         <= be;
         acc_wdata.word <= wdata.word;
         acc_inject     <= inject;
      end
   end

   assign strobe = (state == ST_ACCESS);
   assign ack    = (state == ST_ACK);  // stays up while req held

endmodule : host_port

`default_nettype wire

// File: design/scratchpad_top.sv
`default_nettype none

// scratchpad memory, 256 x 32, two parity lanes
module scratchpad_top import mem_geom_pkg::*, host_if_pkg::*; (
   input  wire logic              clk,
   input  wire logic              reset,
   input  wire logic              req,
   input  wire logic              we,
   input  wire logic [ADDR_W-1:0] addr,
   input  wire logic [BE_W-1:0]   be,
   input  wire data_word_u        wdata,
   input  wire logic              inject,
   output logic                   ack,
   output data_word_u             rdata,
   output logic                   err
);

   logic                          strobe;
   logic                          acc_we;
   logic [ADDR_W-1:0]             acc_addr;
   logic [BE_W-1:0]               acc_be;
   data_word_u                    acc_wdata;
   logic                          acc_inject;
   logic                          done;
   logic [LANES-1:0][LANE_W-1:0]  lane_rdata;
   logic [LANES-1:0]              lane_err;
   logic                          lane0_rvalid;  // paces the merge

   host_port i_host_port (
      .clk (clk), .reset (reset),
      .req (req), .we (we), .addr (addr), .be (be), .wdata (wdata), .inject (inject),
      .done (done), .ack (ack), .strobe (strobe),
      .acc_we (acc_we), .acc_addr (acc_addr), .acc_be (acc_be),
      .acc_wdata (acc_wdata), .acc_inject (acc_inject)
   );

   // low half, bytes 1:0
   parity_lane i_lane0 (
      .clk (clk), .reset (reset), .strobe (strobe), .we (acc_we), .addr (acc_addr),
      .be (acc_be[LANE_BYTES-1:0]), .wdata (acc_wdata.lane[0]), .inject (acc_inject),
      .rdata (lane_rdata[0]), .err (lane_err[0]), .rvalid (lane0_rvalid)
   );

   // high half, bytes 3:2; same timing as lane 0
   parity_lane i_lane1 (
      .clk (clk), .reset (reset), .strobe (strobe), .we (acc_we), .addr (acc_addr),
      .be (acc_be[BE_W-1:LANE_BYTES]), .wdata (acc_wdata.lane[1]), .inject (acc_inject),
      .rdata (lane_rdata[1]), .err (lane_err[1]), .rvalid ()
   );

   lane_merge i_lane_merge (
      .clk (clk), .reset (reset),
      .lane_valid (lane0_rvalid), .lane_data (lane_rdata), .lane_err (lane_err),
      .rdata (rdata), .err (err), .done (done)
   );

endmodule : scratchpad_top

`default_nettype wire

// File: testbench/scratchpad_vectors.svh
`ifndef SCRATCHPAD_VECTORS_SVH
`define SCRATCHPAD_VECTORS_SVH

   // columns: name, we, addr, be, wdata, inject, hold cycles, expected rdata, expected err
   // memory holds {4{addr}} from the fill pass; a write ack returns the old word
   task automatic load_vectors();
      add_step("full_wr",      1'b1, 8'h10, 4'hf, 32'h1234_5678, 1'b0, 0, 32'h1010_1010, 1'b0);
      add_step("full_rd",      1'b0, 8'h10, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h1234_5678, 1'b0);
      add_step("be_low_wr",    1'b1, 8'h10, 4'h3, 32'hdead_beef, 1'b0, 0, 32'h1234_5678, 1'b0);
      add_step("be_low_rd",    1'b0, 8'h10, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h1234_beef, 1'b0);
      add_step("be_b2_wr",     1'b1, 8'h10, 4'h4, 32'hcafe_f00d, 1'b0, 0, 32'h1234_beef, 1'b0);
      add_step("be_b2_rd",     1'b0, 8'h10, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h12fe_beef, 1'b0);
      add_step("be_none_wr",   1'b1, 8'h10, 4'h0, 32'hffff_ffff, 1'b0, 0, 32'h12fe_beef, 1'b0);
      add_step("be_none_rd",   1'b0, 8'h10, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h12fe_beef, 1'b0);
      add_step("rbw_wr1",      1'b1, 8'h20, 4'hf, 32'ha5a5_a5a5, 1'b0, 0, 32'h2020_2020, 1'b0);
      add_step("rbw_wr2",      1'b1, 8'h20, 4'hf, 32'h5a5a_5a5a, 1'b0, 0, 32'ha5a5_a5a5, 1'b0);
      add_step("rbw_rd",       1'b0, 8'h20, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h5a5a_5a5a, 1'b0);
      add_step("inj_on_rd",    1'b0, 8'h20, 4'hf, 32'h0000_0000, 1'b1, 0, 32'h5a5a_5a5a, 1'b0);
      add_step("inj_wr",       1'b1, 8'h30, 4'hf, 32'h0f0f_0f0f, 1'b1, 0, 32'h3030_3030, 1'b0);
      add_step("inj_rd",       1'b0, 8'h30, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h0f0f_0f0f, 1'b1);
      add_step("inj_rewrite",  1'b1, 8'h30, 4'hf, 32'h1122_3344, 1'b0, 0, 32'h0f0f_0f0f, 1'b1);
      add_step("inj_clean_rd", 1'b0, 8'h30, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h1122_3344, 1'b0);
      add_step("inj_b3_wr",    1'b1, 8'h40, 4'h8, 32'h9900_0000, 1'b1, 0, 32'h4040_4040, 1'b0);
      add_step("inj_b3_rd",    1'b0, 8'h40, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h9940_4040, 1'b1);
      add_step("fix_b3_wr",    1'b1, 8'h40, 4'h8, 32'h7700_0000, 1'b0, 0, 32'h9940_4040, 1'b1);
      add_step("fix_b3_rd",    1'b0, 8'h40, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h7740_4040, 1'b0);
      add_step("inj_b0_wr",    1'b1, 8'h40, 4'h1, 32'h0000_00ee, 1'b1, 0, 32'h7740_4040, 1'b0);
      add_step("inj_b0_rd",    1'b0, 8'h40, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h7740_40ee, 1'b1);
      add_step("hold_rd",      1'b0, 8'h10, 4'hf, 32'h0000_0000, 1'b0, 4, 32'h12fe_beef, 1'b0);
      add_step("hold_wr",      1'b1, 8'h50, 4'hf, 32'h0bad_f00d, 1'b0, 2, 32'h5050_5050, 1'b0);
      add_step("hold_wr_rd",   1'b0, 8'h50, 4'hf, 32'h0000_0000, 1'b0, 0, 32'h0bad_f00d, 1'b0);
   endtask

`endif

// File: testbench/scratchpad_tb.sv
`default_nettype none

// scratchpad testbench with fill pass, directed table and seeded random accesses
module scratchpad_tb import mem_geom_pkg::*, host_if_pkg::*;;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_HALF  = 4;        // 8 ns period
   localparam int RST_CYC   = 8;
   localparam int WORDS     = 2**ADDR_W;
   localparam int MAX_VEC   = 32;       // table capacity
   localparam int NUM_RAND  = 48;
   localparam int ACK_EDGES = 4;        // sampling edge plus three more
   localparam int STEP_CYC  = 20;       // budget per access

   logic              clk;
   logic              reset;
   logic              req;
   logic              we;
   logic [ADDR_W-1:0] addr;
   logic [BE_W-1:0]   be;
   data_word_u        wdata;
   logic              inject;
   logic              ack;
   data_word_u        rdata;
   logic              err;

   string             vec_name   [MAX_VEC];  // directed steps
   logic              vec_we     [MAX_VEC];
   logic [ADDR_W-1:0] vec_addr   [MAX_VEC];
   logic [BE_W-1:0]   vec_be     [MAX_VEC];
   logic [DATA_W-1:0] vec_wdata  [MAX_VEC];
   logic              vec_inject [MAX_VEC];
   int                vec_hold   [MAX_VEC];  // extra cycles with req held
   logic [DATA_W-1:0] vec_rdata  [MAX_VEC];
   logic              vec_err    [MAX_VEC];
   int                n_vec;

   logic [DATA_W-1:0] model     [WORDS];     // expected memory contents
   logic [BE_W-1:0]   model_bad [WORDS];     // bytes stored with bad parity
   int                n_pass;
   int                n_fail;

   scratchpad_top i_scratchpad_top (
      .clk (clk), .reset (reset), .req (req), .we (we), .addr (addr), .be (be),
      .wdata (wdata), .inject (inject), .ack (ack), .rdata (rdata), .err (err)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   task automatic add_step(input string name, input logic w, input logic [ADDR_W-1:0] a,
                           input logic [BE_W-1:0] b, input logic [DATA_W-1:0] d,
                           input logic inj, input int hold,
                           input logic [DATA_W-1:0] exp_d, input logic exp_e);
      vec_name[n_vec]   = name;
      vec_we[n_vec]     = w;
      vec_addr[n_vec]   = a;
      vec_be[n_vec]     = b;
      vec_wdata[n_vec]  = d;
      vec_inject[n_vec] = inj;
      vec_hold[n_vec]   = hold;
      vec_rdata[n_vec]  = exp_d;
      vec_err[n_vec]    = exp_e;
      n_vec++;
   endtask

   `include "scratchpad_vectors.svh"

   // one four-phase transfer with timing checks and optional data checks
   task automatic run_handshake(input string name, input logic w, input logic [ADDR_W-1:0] a,
                                input logic [BE_W-1:0] b, input logic [DATA_W-1:0] d,
                                input logic inj, input int hold, input logic check,
                                input logic [DATA_W-1:0] exp_d, input logic exp_e,
                                output int errs);
      int edges;
      errs  = 0;
      edges = 0;
      @(posedge clk);
      req        <= 1'b1;
      we         <= w;
      addr       <= a;
      be         <= b;
      wdata.word <= d;
      inject     <= inj;
      do begin
         @(posedge clk);
         edges++;
         @(negedge clk);                       // sample away from the edge
      end while (ack !== 1'b1);
      assert (edges == ACK_EDGES) else begin
         $display("Fail %s ack latency expected %0d actual %0d", name, ACK_EDGES - 1, edges - 1);
         errs++;
      end
      if (check) begin
         assert (rdata.word === exp_d) else begin
            $display("Fail %s rdata expected %h actual %h", name, exp_d, rdata.word);
            errs++;
         end
         assert (err === exp_e) else begin
            $display("Fail %s err expected %b actual %b", name, exp_e, err);
            errs++;
         end
      end
      repeat (hold) begin
         @(negedge clk);                       // ack and data hold under back-pressure
         assert (ack === 1'b1) else begin
            $display("Fail %s held ack expected 1 actual %b", name, ack);
            errs++;
         end
         if (check) begin
            assert (rdata.word === exp_d && err === exp_e) else begin
               $display("Fail %s held rdata/err expected %h/%b actual %h/%b", name, exp_d,
                        exp_e, rdata.word, err);
               errs++;
            end
         end
      end
      @(posedge clk);
      req <= 1'b0;
      @(posedge clk);                          // this edge samples req low
      @(negedge clk);
      assert (ack === 1'b0) else begin
         $display("Fail %s ack after req drop expected 0 actual %b", name, ack);
         errs++;
      end
   endtask

   task automatic update_model(input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] b,
                               input logic [DATA_W-1:0] d, input logic inj);
      for (int i = 0; i < BE_W; i++) begin
         if (b[i]) begin
            model[a][i*BYTE_W +: BYTE_W] = d[i*BYTE_W +: BYTE_W];
            model_bad[a][i]              = inj;  // parity of this byte follows inject
         end
      end
   endtask

   task automatic report_test(input string name, input int errs);
      if (errs == 0) begin
         n_pass++;
         $display("test %s: ok", name);
      end else begin
         n_fail++;
         $display("test %s: %0d errors", name, errs);
      end
   endtask

   initial begin
      int                seed;
      int                errs;
      int                e;
      logic              r_we;
      logic [ADDR_W-1:0] r_addr;
      logic [BE_W-1:0]   r_be;
      logic [DATA_W-1:0] r_data;
      logic              r_inj;
      seed   = $urandom(74);
      n_vec  = 0;
      n_pass = 0;
      n_fail = 0;
      reset  = 1'b1;
      req    = 1'b0;
      we     = 1'b0;
      addr   = '0;
      be     = '0;
      wdata  = '0;
      inject = 1'b0;
      load_vectors();
      repeat (RST_CYC) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      errs = 0;
      assert (ack === 1'b0) else begin
         $display("Fail reset_ack ack expected 0 actual %b", ack);
         errs++;
      end
      report_test("reset_ack", errs);
      errs = 0;
      for (int a = 0; a < WORDS; a++) begin  // old data unknown so timing only
         run_handshake("fill", 1'b1, a[ADDR_W-1:0], '1, {BE_W{a[BYTE_W-1:0]}}, 1'b0, 0,
                       1'b0, '0, 1'b0, e);
         errs += e;
         model[a]     = {BE_W{a[BYTE_W-1:0]}};
         model_bad[a] = '0;
      end
      report_test("fill_all", errs);
      for (int i = 0; i < n_vec; i++) begin
         run_handshake(vec_name[i], vec_we[i], vec_addr[i], vec_be[i], vec_wdata[i],
                       vec_inject[i], vec_hold[i], 1'b1, vec_rdata[i], vec_err[i], errs);
         if (vec_we[i]) update_model(vec_addr[i], vec_be[i], vec_wdata[i], vec_inject[i]);
         report_test(vec_name[i], errs);
      end
      for (int i = 0; i < NUM_RAND; i++) begin
         r_we   = $urandom_range(0, 1);
         r_addr = $urandom_range(0, WORDS - 1);
         r_be   = $urandom_range(0, 2**BE_W - 1);
         r_data = $urandom;
         r_inj  = ($urandom_range(0, 7) == 0);  // occasional bad parity
         run_handshake($sformatf("random_%0d", i), r_we, r_addr, r_be, r_data, r_inj, 0,
                       1'b1, model[r_addr], |model_bad[r_addr], errs);
         if (r_we) update_model(r_addr, r_be, r_data, r_inj);
         report_test($sformatf("random_%0d", i), errs);
      end
      $display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
      if (n_fail == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // hang guard sized from reset plus every access
   initial begin
      #((RST_CYC + (1 + WORDS + MAX_VEC + NUM_RAND) * STEP_CYC) * 2 * CLK_HALF);
      $display("watchdog: the DUT did not finish the handshake in time, run stopped");
      $display("Simulation failed");
      $finish;
   end

endmodule : scratchpad_tb

`default_nettype wire

// File: flist.f
+incdir+testbench
common/mem_geom_pkg.sv
common/host_if_pkg.sv
design/la_spram.sv
parity_lane/parity_lane.sv
design/lane_merge.sv
design/host_port.sv
design/scratchpad_top.sv
testbench/scratchpad_tb.sv

// File: Bender.yml
package:
  name: scratchpad

sources:
  - files:
      - common/mem_geom_pkg.sv
      - common/host_if_pkg.sv
      - design/la_spram.sv
      - parity_lane/parity_lane.sv
      - design/lane_merge.sv
      - design/host_port.sv
      - design/scratchpad_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/scratchpad_tb.sv
